// ==== axi_sys.f ====
axi_pkg.sv
sys_pkg.sv
axi_slave.sv
sys_bus_decoder.sv
reg_bank.sv
slow_mem.sv
axi_sys_top.sv
tb_axi_sys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The run passes only if the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_axi_sys -f axi_sys.f -o sim_axi_sys \
   && ./obj_dir/sim_axi_sys | tee /dev/stderr | grep -qx "TEST OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== tb_axi_sys.sv ====
// single-beat AXI master; aw and w are driven together and outputs are sampled on the falling edge
`timescale 1ns/1ps

module tb_axi_sys;
   import axi_pkg::*;
   import sys_pkg::*;

   localparam logic [1:0] op_wr   = 2'd0;
   localparam logic [1:0] op_rd   = 2'd1;
   localparam logic [1:0] op_both = 2'd2;   // aw and ar in the same cycle

   typedef struct packed {
      logic [1:0]            op;
      logic [sys_aw-1:0]     addr;
      logic [axi_len_w-1:0]  len;
      logic [axi_size_w-1:0] size;
      logic                  rnd;    // lfsr write data and read checked against the shadow
      logic [axi_resp_w-1:0] resp;
      logic [sys_dw-1:0]     data;   // fixed write data or expected read data
   } test_t;

   logic axi = 1'b0;
   logic rst;
   logic [axi_id_w-1:0]   awid, arid, bid, rid;
   logic [sys_aw-1:0]     awaddr, araddr;
   logic [axi_len_w-1:0]  awlen, arlen;
   logic [axi_size_w-1:0] awsize, arsize;
   logic [sys_dw-1:0]     wdata, rdata;
   logic [axi_resp_w-1:0] bresp, rresp;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rlast, rvalid, rready;

   test_t             tbl[$];
   logic [15:0]       lfsr = 16'd98;
   logic [sys_dw-1:0] shadow_reg [0:reg_num-1];
   logic [sys_dw-1:0] shadow_mem [0:mem_words-1];
   int                err_cnt = 0;
   int                chk_cnt = 0;

   axi_sys_top UUT (.*);

   always #4 axi = ~axi;   // 8 ns

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);   // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic void add_test(input logic [1:0] op, input logic [31:0] a,
                                    input logic [3:0] len, input logic [2:0] size,
                                    input logic rnd, input logic [1:0] resp,
                                    input logic [31:0] data);
      test_t t;
      t = '{op, a, len, size, rnd, resp, data};
      tbl.push_back(t);
   endfunction

   // address map as the bus sees it
   function automatic logic [31:0] predict_read(input logic [31:0] a);
      if ((a & ~reg_mask) == reg_base)
         return (a[4:2] == 3'd7) ? reg_id_value : shadow_reg[a[4:2]];
      return shadow_mem[a[7:2]];
   endfunction

   function automatic void record_write(input logic [31:0] a, input logic [31:0] d);
      if ((a & ~reg_mask) == reg_base) begin
         if (a[4:2] != 3'd7)
            shadow_reg[a[4:2]] = d;   // identifier ignores writes
      end else if ((a & ~mem_mask) == mem_base) begin
         shadow_mem[a[7:2]] = d;
      end
   endfunction

   ////////////////////////////////////////
   // AXI master tasks
   ////////////////////////////////////////

   task automatic write_addr(input logic [31:0] a, input logic [3:0] len,
                             input logic [2:0] size, input logic [31:0] d,
                             input logic [7:0] id, input logic with_rd);
      @(posedge axi);
      awid    <= id;
      awaddr  <= a;
      awlen   <= len;
      awsize  <= size;
      wdata   <= d;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      if (with_rd) begin   // read to the same register offered alongside
         arid    <= id + 8'd1;
         araddr  <= a;
         arlen   <= len;
         arsize  <= size;
         arvalid <= 1'b1;
      end
      @(negedge axi);
      while (!awready) @(negedge axi);
      check_val("wready with awready", 32'(wready), 32'd1);
      if (with_rd)
         check_val("arready while awvalid", 32'(arready), 32'd0);   // write wins
      @(posedge axi);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
   endtask

   task automatic read_addr(input logic [31:0] a, input logic [3:0] len,
                            input logic [2:0] size, input logic [7:0] id);
      @(posedge axi);
      arid    <= id;
      araddr  <= a;
      arlen   <= len;
      arsize  <= size;
      arvalid <= 1'b1;
      @(negedge axi);
      while (!arready) @(negedge axi);
      @(posedge axi);
      arvalid <= 1'b0;
   endtask

   task automatic bresp_wait(input logic [7:0] id, input logic [1:0] resp, input int hold);
      logic [9:0] snap;
      @(negedge axi);
      while (!bvalid) @(negedge axi);
      snap = {bid, bresp};
      repeat (hold) begin   // back-pressure
         @(negedge axi);
         check_val("bvalid held", 32'(bvalid), 32'd1);
         check_val("b payload stable", 32'({bid, bresp}), 32'(snap));
      end
      check_val("bid", 32'(bid), 32'(id));
      check_val("bresp", 32'(bresp), 32'(resp));
      @(posedge axi);
      bready <= 1'b1;
      @(posedge axi);     // handshake on this edge
      bready <= 1'b0;
   endtask

   task automatic rdata_wait(input logic [7:0] id, input logic [1:0] resp,
                             input logic [31:0] exp, input int hold);
      logic [41:0] snap;
      @(negedge axi);
      while (!rvalid) @(negedge axi);
      snap = {rid, rresp, rdata};
      repeat (hold) begin
         @(negedge axi);
         check_val("rvalid held", 32'(rvalid), 32'd1);
         check_val("r payload stable", 32'({rid, rresp, rdata} != snap), 32'd0);
      end
      check_val("rid", 32'(rid), 32'(id));
      check_val("rresp", 32'(rresp), 32'(resp));
      check_val("rdata", rdata, exp);
      check_val("rlast", 32'(rlast), 32'd1);
      @(posedge axi);
      rready <= 1'b1;
      @(posedge axi);
      rready <= 1'b0;
   endtask

   ////////////////////////////////////////
   // watchdog and main sequence
   ////////////////////////////////////////

   initial begin
      #1;   // table is filled at time zero
      #(tbl.size() * (ack_timeout + 40) * 8);
      $display("watchdog: the DUT stopped answering, run aborted");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      test_t             t;
      logic [31:0]       d;
      logic [31:0]       exp;
      logic [axi_id_w-1:0] id;
      int                hold;
      rst     = 1'b1;
      awid    = '0;
      awaddr  = '0;
      awlen   = '0;
      awsize  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      arid    = '0;
      araddr  = '0;
      arlen   = '0;
      arsize  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      id      = 8'h10;
      for (int i = 0; i < reg_num; i++)
         shadow_reg[i] = '0;
      for (int i = 0; i < 7; i++)
         add_test(op_wr, 4 * i, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_rd, 32'h1c, 4'd0, axi_size_word, 1'b0, axi_resp_okay, reg_id_value);
      for (int i = 0; i < 7; i++)
         add_test(op_rd, 4 * i, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_wr, 32'h1c, 4'd0, axi_size_word, 1'b0, axi_resp_okay, 32'hdead_beef);
      add_test(op_rd, 32'h1c, 4'd0, axi_size_word, 1'b0, axi_resp_okay, reg_id_value);
      // memory read back out of order
      add_test(op_wr, 32'h0001_0014, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_wr, 32'h0001_00fc, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_wr, 32'h0001_0000, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_rd, 32'h0001_00fc, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_wr, 32'h0001_0044, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_rd, 32'h0001_0014, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_rd, 32'h0001_0044, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_rd, 32'h0001_0000, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      // unmapped addresses answered by the timeout
      add_test(op_wr, 32'h0002_0000, 4'd0, axi_size_word, 1'b0, axi_resp_slverr, 32'h1234_5678);
      add_test(op_rd, 32'h0000_1000, 4'd0, axi_size_word, 1'b0, axi_resp_slverr, 0);
      add_test(op_rd, 32'h0000_0000, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      // bursts and narrow sizes on register 2
      add_test(op_wr, 32'h8, 4'd3, axi_size_word, 1'b0, axi_resp_slverr, 32'hffff_ffff);
      add_test(op_wr, 32'h8, 4'd0, 3'b001, 1'b0, axi_resp_slverr, 32'hffff_ffff);
      add_test(op_rd, 32'h8, 4'd2, axi_size_word, 1'b0, axi_resp_slverr, 0);
      add_test(op_rd, 32'h8, 4'd0, 3'b011, 1'b0, axi_resp_slverr, 0);
      add_test(op_rd, 32'h8, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_both, 32'hc, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      add_test(op_both, 32'h0001_0024, 4'd0, axi_size_word, 1'b1, axi_resp_okay, 0);
      repeat (4) @(posedge axi);
      rst <= 1'b0;
      foreach (tbl[n]) begin
         t    = tbl[n];
         d    = (t.rnd && t.op != op_rd) ? rand_bits(32) : t.data;
         hold = int'(rand_bits(2));   // 0 to 3 extra cycles of back-pressure
         if (t.op == op_rd) begin
            exp = (t.resp != axi_resp_okay) ? '0 : (t.rnd ? predict_read(t.addr) : t.data);
            read_addr(t.addr, t.len, t.size, id);
            rdata_wait(id, t.resp, exp, hold);
         end else begin
            write_addr(t.addr, t.len, t.size, d, id, t.op == op_both);
            if (t.op == op_both) begin
               @(negedge axi);
               while (!bvalid) @(negedge axi);
               check_val("no read before write response", 32'(rvalid), 32'd0);
            end
            bresp_wait(id, t.resp, hold);
            if (t.resp == axi_resp_okay)
               record_write(t.addr, d);
            if (t.op == op_both) begin
               @(negedge axi);
               while (!arready) @(negedge axi);
               @(posedge axi);
               arvalid <= 1'b0;
               id = id + 8'd1;
               rdata_wait(id, t.resp, predict_read(t.addr), hold);
            end
         end
         id = id + 8'd1;
      end
      repeat (2) @(posedge axi);
      $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== axi_sys_top.sv ====
// AXI port behaves as axi_slave: single-beat word accesses, aw and w offered in the same cycle
`timescale 1ns/1ps

module axi_sys_top (
   input  logic                            axi,
   input  logic                            rst,
   input  logic [axi_pkg::axi_id_w-1:0]    awid,
   input  logic [sys_pkg::sys_aw-1:0]      awaddr,
   input  logic [axi_pkg::axi_len_w-1:0]   awlen,
   input  logic [axi_pkg::axi_size_w-1:0]  awsize,
   input  logic                            awvalid,
   output logic                            awready,
   input  logic [sys_pkg::sys_dw-1:0]      wdata,
   input  logic                            wvalid,
   output logic                            wready,
   output logic [axi_pkg::axi_id_w-1:0]    bid,
   output logic [axi_pkg::axi_resp_w-1:0]  bresp,
   output logic                            bvalid,
   input  logic                            bready,
   input  logic [axi_pkg::axi_id_w-1:0]    arid,
   input  logic [sys_pkg::sys_aw-1:0]      araddr,
   input  logic [axi_pkg::axi_len_w-1:0]   arlen,
   input  logic [axi_pkg::axi_size_w-1:0]  arsize,
   input  logic                            arvalid,
   output logic                            arready,
   output logic [axi_pkg::axi_id_w-1:0]    rid,
   output logic [sys_pkg::sys_dw-1:0]      rdata,
   output logic [axi_pkg::axi_resp_w-1:0]  rresp,
   output logic                            rlast,
   output logic                            rvalid,
   input  logic                            rready
);
   import sys_pkg::*;

   // bridge side of the system bus
   logic [sys_aw-1:0] bus_addr;
   logic [sys_dw-1:0] bus_wdata;
   logic              bus_wen;
   logic              bus_ren;
   logic [sys_dw-1:0] bus_rdata;
   logic              bus_ack;
   // target side
   logic [sys_aw-1:0] tgt_addr;
   logic [sys_dw-1:0] tgt_wdata;
   logic              reg_wen;
   logic              reg_ren;
   logic [sys_dw-1:0] reg_rdata;
   logic              reg_ack;
   logic              mem_wen;
   logic              mem_ren;
   logic [sys_dw-1:0] mem_rdata;
   logic              mem_ack;

   axi_slave u_bridge (
      .axi(axi), .rst(rst),
      .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
      .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wvalid(wvalid), .wready(wready),
      .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
      .arvalid(arvalid), .arready(arready),
      .rid(rid), .rdata(rdata), .rresp(rresp), .rlast(rlast),
      .rvalid(rvalid), .rready(rready),
      .addr(bus_addr), .bus_wdata(bus_wdata), .wen(bus_wen), .ren(bus_ren),
      .bus_rdata(bus_rdata), .ack(bus_ack)
   );

   sys_bus_decoder u_dec (
      .axi(axi), .rst(rst),
      .addr(bus_addr), .wdata(bus_wdata), .wen(bus_wen), .ren(bus_ren),
      .rdata(bus_rdata), .ack(bus_ack),
      .reg_wen(reg_wen), .reg_ren(reg_ren), .reg_rdata(reg_rdata), .reg_ack(reg_ack),
      .mem_wen(mem_wen), .mem_ren(mem_ren), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
      .tgt_addr(tgt_addr), .tgt_wdata(tgt_wdata)
   );

   // fast target
   reg_bank u_regs (
      .axi(axi), .rst(rst), .wen(reg_wen), .ren(reg_ren),
      .addr(tgt_addr), .wdata(tgt_wdata), .rdata(reg_rdata), .ack(reg_ack)
   );

   // slow target
   slow_mem u_mem (
      .axi(axi), .rst(rst), .wen(mem_wen), .ren(mem_ren),
      .addr(tgt_addr), .wdata(tgt_wdata), .rdata(mem_rdata), .ack(mem_ack)
   );

endmodule

// ==== slow_mem.sv ====
// 64-word memory with fixed wait states; contents undefined after reset, one access in flight
`timescale 1ns/1ps

module slow_mem (
   input  logic                        axi,
   input  logic                        rst,
   input  logic                        wen,
   input  logic                        ren,
   input  logic [sys_pkg::sys_aw-1:0]  addr,
   input  logic [sys_pkg::sys_dw-1:0]  wdata,
   output logic [sys_pkg::sys_dw-1:0]  rdata,
   output logic                        ack
);
   import sys_pkg::*;

   logic [sys_dw-1:0]     mem [0:mem_words-1];
   logic [mem_idx_w-1:0]  idx;
   logic [mem_wait_w-1:0] wait_cnt;   // zero when idle
   logic                  last_wait;

   assign idx       = addr[mem_idx_w+1:2];   // word offset, bits 7:2
   assign last_wait = (wait_cnt == mem_wait_w'(1));

   ////////////////////////////////////////
   // wait counter
   ////////////////////////////////////////

   always_ff @(posedge axi) begin
      if (rst) begin
         wait_cnt <= '0;
         ack      <= 1'b0;
      end else begin
         ack <= last_wait;   // lands mem_wait cycles after the strobe
         if (wen | ren)
            wait_cnt <= mem_wait_w'(mem_wait - 1);
         else if (wait_cnt != '0)
            wait_cnt <= wait_cnt - mem_wait_w'(1);
      end
   end

   ////////////////////////////////////////
   // storage
   ////////////////////////////////////////

   always_ff @(posedge axi) begin
      if (wen)
         mem[idx] <= wdata;   // write right on the strobe
      if (last_wait)
         rdata <= mem[idx];   // addr still held by the bridge
   end

endmodule

// ==== reg_bank.sv ====
// eight word registers, aliased over the 4 KiB window; the last one is a read-only identifier
`timescale 1ns/1ps

module reg_bank (
   input  logic                        axi,
   input  logic                        rst,
   input  logic                        wen,
   input  logic                        ren,
   input  logic [sys_pkg::sys_aw-1:0]  addr,
   input  logic [sys_pkg::sys_dw-1:0]  wdata,
   output logic [sys_pkg::sys_dw-1:0]  rdata,
   output logic                        ack
);
   import sys_pkg::*;

   logic [sys_dw-1:0]    regs [0:reg_num-1];
   logic [reg_idx_w-1:0] idx;
   logic                 id_sel;   // points at the identifier

   assign idx    = addr[reg_idx_w+1:2];   // word offset
   assign id_sel = (idx == reg_idx_w'(reg_num - 1));

   ////////////////////////////////////////
   // register storage
   ////////////////////////////////////////

   always_ff @(posedge axi) begin
      if (rst) begin
         for (int i = 0; i < reg_num; i++) begin
            // identifier loads here and is never written
            regs[i] <= (i == reg_num - 1) ? reg_id_value : '0;
         end
      end else if (wen && !id_sel) begin
         regs[idx] <= wdata;
      end
      // write to the identifier is acked, data dropped
   end

   ////////////////////////////////////////
   // ack and read data
   ////////////////////////////////////////

   // one cycle after the strobe
   always_ff @(posedge axi) begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= wen | ren;   // writes and reads alike
   end

   always_ff @(posedge axi) begin
      if (ren)
         rdata <= regs[idx];   // valid together with ack
   end

endmodule

// ==== sys_bus_decoder.sv ====
// strobes to unmapped addresses are dropped, so only the bridge timeout answers them
`timescale 1ns/1ps

module sys_bus_decoder (
   input  logic                        axi,
   input  logic                        rst,
   // from the bridge
   input  logic [sys_pkg::sys_aw-1:0]  addr,
   input  logic [sys_pkg::sys_dw-1:0]  wdata,
   input  logic                        wen,
   input  logic                        ren,
   // to the bridge
   output logic [sys_pkg::sys_dw-1:0]  rdata,
   output logic                        ack,
   // register bank
   output logic                        reg_wen,
   output logic                        reg_ren,
   input  logic [sys_pkg::sys_dw-1:0]  reg_rdata,
   input  logic                        reg_ack,
   // memory
   output logic                        mem_wen,
   output logic                        mem_ren,
   input  logic [sys_pkg::sys_dw-1:0]  mem_rdata,
   input  logic                        mem_ack,
   // shared to both targets
   output logic [sys_pkg::sys_aw-1:0]  tgt_addr,
   output logic [sys_pkg::sys_dw-1:0]  tgt_wdata
);
   import sys_pkg::*;

   logic reg_hit;
   logic mem_hit;
   logic sel_reg;   // region recorded at strobe time
   logic sel_mem;

   // region match, offset bits masked off
   assign reg_hit = ((addr & ~reg_mask) == reg_base);
   assign mem_hit = ((addr & ~mem_mask) == mem_base);

   // strobes only go to the matching target
   assign reg_wen = wen & reg_hit;
   assign reg_ren = ren & reg_hit;
   assign mem_wen = wen & mem_hit;
   assign mem_ren = ren & mem_hit;

   assign tgt_addr  = addr;    // bridge keeps these stable
   assign tgt_wdata = wdata;

   always_ff @(posedge axi) begin
      if (rst) begin
         sel_reg <= 1'b0;
         sel_mem <= 1'b0;
      end else if (wen | ren) begin
         sel_reg <= reg_hit;
         sel_mem <= mem_hit;
      end else if (ack) begin
         sel_reg <= 1'b0;      // access over
         sel_mem <= 1'b0;
      end
   end

   // return path follows the record, not the live address
   always_comb begin
      rdata = '0;
      ack   = 1'b0;
      if (sel_reg) begin
         rdata = reg_rdata;
         ack   = reg_ack;
      end else if (sel_mem) begin
         rdata = mem_rdata;
         ack   = mem_ack;
      end
   end

endmodule

// ==== axi_slave.sv ====
// one access at a time with write priority; aw and w handshake together; single beats only
`timescale 1ns/1ps

module axi_slave (
   input  logic                            axi,
   input  logic                            rst,
   // write address
   input  logic [axi_pkg::axi_id_w-1:0]    awid,
   input  logic [sys_pkg::sys_aw-1:0]      awaddr,
   input  logic [axi_pkg::axi_len_w-1:0]   awlen,
   input  logic [axi_pkg::axi_size_w-1:0]  awsize,
   input  logic                            awvalid,
   output logic                            awready,
   // write data
   input  logic [sys_pkg::sys_dw-1:0]      wdata,
   input  logic                            wvalid,
   output logic                            wready,
   // write response
   output logic [axi_pkg::axi_id_w-1:0]    bid,
   output logic [axi_pkg::axi_resp_w-1:0]  bresp,
   output logic                            bvalid,
   input  logic                            bready,
   // read address
   input  logic [axi_pkg::axi_id_w-1:0]    arid,
   input  logic [sys_pkg::sys_aw-1:0]      araddr,
   input  logic [axi_pkg::axi_len_w-1:0]   arlen,
   input  logic [axi_pkg::axi_size_w-1:0]  arsize,
   input  logic                            arvalid,
   output logic                            arready,
   // read data
   output logic [axi_pkg::axi_id_w-1:0]    rid,
   output logic [sys_pkg::sys_dw-1:0]      rdata,
   output logic [axi_pkg::axi_resp_w-1:0]  rresp,
   output logic                            rlast,
   output logic                            rvalid,
   input  logic                            rready,
   // system bus
   output logic [sys_pkg::sys_aw-1:0]      addr,
   output logic [sys_pkg::sys_dw-1:0]      bus_wdata,
   output logic                            wen,
   output logic                            ren,
   input  logic [sys_pkg::sys_dw-1:0]      bus_rdata,
   input  logic                            ack
);
   import axi_pkg::*;
   import sys_pkg::*;

   logic                   wr_busy;   // write owns the bridge until b handshake
   logic                   rd_busy;   // read owns it until r handshake
   logic                   pend;      // strobe out, waiting for ack or timeout
   logic                   unsup_q;   // latched burst / size error
   logic [ack_cnt_w-1:0]   ack_cnt;
   logic [axi_id_w-1:0]    id_q;
   logic                   idle;
   logic                   wr_acc;
   logic                   rd_acc;
   logic                   wr_unsup;
   logic                   rd_unsup;
   logic                   timeout;
   logic                   done;
   logic [axi_resp_w-1:0]  resp;

   ////////////////////////////////////////
   // address acceptance
   ////////////////////////////////////////

   assign idle    = ~wr_busy & ~rd_busy;
   assign awready = idle & wvalid;       // aw and w taken in one handshake
   assign wready  = idle & awvalid;
   assign arready = idle & ~awvalid;     // write has priority

   assign wr_acc = awvalid & awready;
   assign rd_acc = arvalid & arready;

   // only single 4-byte beats reach the bus
   assign wr_unsup = (awlen != axi_len_single) | (awsize != axi_size_word);
   assign rd_unsup = (arlen != axi_len_single) | (arsize != axi_size_word);

   // payload held stable for the whole access
   always_ff @(posedge axi) begin
      if (wr_acc) begin
         id_q      <= awid;
         addr      <= awaddr;
         bus_wdata <= wdata;
         unsup_q   <= wr_unsup;
      end else if (rd_acc) begin
         id_q      <= arid;
         addr      <= araddr;
         unsup_q   <= rd_unsup;
      end
   end

   assign bid = id_q;   // echo only without reordering
   assign rid = id_q;

   ////////////////////////////////////////
   // bus strobes and ack protection
   ////////////////////////////////////////

   assign timeout = (ack_cnt == ack_cnt_w'(ack_timeout));
   assign done    = pend & (unsup_q | ack | timeout);   // access ends here

   // ack beats timeout if both land together
   assign resp = (unsup_q | ~ack) ? axi_resp_slverr : axi_resp_okay;

   always_ff @(posedge axi) begin
      if (rst) begin
         wr_busy <= 1'b0;
         rd_busy <= 1'b0;
         pend    <= 1'b0;
         ack_cnt <= '0;
         wen     <= 1'b0;
         ren     <= 1'b0;
      end else begin
         wen <= wr_acc & ~wr_unsup;   // one-cycle strobe in the cycle after T
         ren <= rd_acc & ~rd_unsup;

         if (wr_acc)
            wr_busy <= 1'b1;
         else if (bvalid & bready)
            wr_busy <= 1'b0;          // next access in the following cycle

         if (rd_acc)
            rd_busy <= 1'b1;
         else if (rvalid & rready)
            rd_busy <= 1'b0;

         // counter runs from T until the access ends
         if (wr_acc | rd_acc) begin
            pend    <= 1'b1;
            ack_cnt <= ack_cnt_w'(1);
         end else if (done) begin
            pend    <= 1'b0;
            ack_cnt <= '0;
         end else if (pend) begin
            ack_cnt <= ack_cnt + ack_cnt_w'(1);
         end
      end
   end

   ////////////////////////////////////////
   // responses
   ////////////////////////////////////////

   always_ff @(posedge axi) begin
      if (rst) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
         rlast  <= 1'b0;
      end else begin
         if (done & wr_busy)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;           // held until the master takes it

         if (done & rd_busy) begin
            rvalid <= 1'b1;
            rlast  <= 1'b1;           // every read is a single beat
         end else if (rready) begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
         end
      end
   end

   // response payload only moves at the end of an access
   always_ff @(posedge axi) begin
      if (done & wr_busy)
         bresp <= resp;
      if (done & rd_busy) begin
         rresp <= resp;
         rdata <= (resp == axi_resp_okay) ? bus_rdata : '0;   // zero on any error
      end
   end

endmodule

// ==== sys_pkg.sv ====
// system bus constants; two 4 KiB regions, everything else unmapped and left to the timeout
package sys_pkg;

   ////////////////////////////////////////
   // bus widths
   ////////////////////////////////////////

   localparam int unsigned sys_aw = 32;
   localparam int unsigned sys_dw = 32;

   ////////////////////////////////////////
   // address map
   ////////////////////////////////////////

   // mask covers the offset bits inside a window
   localparam logic [sys_aw-1:0] reg_base = 32'h0000_0000;
   localparam logic [sys_aw-1:0] reg_mask = 32'h0000_0fff;
   localparam logic [sys_aw-1:0] mem_base = 32'h0001_0000;
   localparam logic [sys_aw-1:0] mem_mask = 32'h0000_0fff;

   localparam int unsigned reg_num   = 8;   // word offset bits 4:2
   localparam int unsigned reg_idx_w = 3;
   localparam int unsigned mem_words = 64;  // word offset bits 7:2
   localparam int unsigned mem_idx_w = 6;

   // read-only identifier in the last register
   localparam logic [sys_dw-1:0] reg_id_value = 32'h5a17_0107;

   ////////////////////////////////////////
   // timing
   ////////////////////////////////////////

   localparam int unsigned mem_wait    = 4;   // strobe to ack, memory
   localparam int unsigned mem_wait_w  = $clog2(mem_wait + 1);
   localparam int unsigned ack_timeout = 32;  // bridge gives up after this
   localparam int unsigned ack_cnt_w   = $clog2(ack_timeout + 1);

endpackage

// ==== axi_pkg.sv ====
// AXI constants for single-beat word access only; no bursts, no narrow sizes, no write strobes
package axi_pkg;

   ////////////////////////////////////////
   // field widths
   ////////////////////////////////////////

   localparam int unsigned axi_id_w   = 8;  // awid, arid, bid, rid
   localparam int unsigned axi_len_w  = 4;  // awlen, arlen
   localparam int unsigned axi_size_w = 3;  // awsize, arsize
   localparam int unsigned axi_resp_w = 2;  // bresp, rresp

   ////////////////////////////////////////
   // response codes
   ////////////////////////////////////////

   // exokay and decerr are never produced by the bridge
   localparam logic [axi_resp_w-1:0] axi_resp_okay   = 2'b00;
   localparam logic [axi_resp_w-1:0] axi_resp_slverr = 2'b10;  // also used on timeout

   ////////////////////////////////////////
   // supported transfer
   ////////////////////////////////////////

   // 3'b010 is 4 bytes per beat
   localparam logic [axi_size_w-1:0] axi_size_word = 3'b010;

   // single beat: axlen must be zero
   localparam logic [axi_len_w-1:0]  axi_len_single = '0;

endpackage
